// ==== hw/perf_pkg.sv ====
package perf_pkg;

  // ---------------------------------------------------------------------
  // bus and counter widths
  // ---------------------------------------------------------------------
  localparam int addr_width = 20;
  localparam int data_width = 16;
  localparam int id_width   = 4;
  localparam int strb_width = data_width / 8;
  localparam int stat_width = 32;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [id_width-1:0]   id_t;
  typedef logic [7:0]            beats_t;
  typedef logic [15:0]           burst_cnt_t;
  typedef logic [2:0]            size_t;
  typedef logic [1:0]            resp_t;
  typedef logic [stat_width-1:0] stat_t;

  // axi encodings
  localparam logic [1:0] burst_incr = 2'b01;
  localparam resp_t      resp_okay  = 2'b00;

  // ---------------------------------------------------------------------
  // run configuration and channel payloads
  // ---------------------------------------------------------------------
  typedef struct packed {
    addr_t      base_addr;
    beats_t     burst_beats;
    addr_t      burst_stride;
    burst_cnt_t burst_num;
    size_t      awsize;
  } perf_cfg_t;

  typedef struct packed {
    addr_t      addr;
    id_t        id;
    beats_t     len;
    size_t      size;
    logic [1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } axi_b_t;

  typedef struct packed {
    stat_t aw_count;
    stat_t w_count;
    stat_t b_count;
    stat_t b_err_count;
  } perf_stats_t;

  typedef enum logic {IDLE, RUNNING} run_state_t;

  typedef enum logic [1:0] {ADDR, DATA, RESP} wr_phase_t;

endpackage

// ==== hw/perf_run_ctrl.sv ====
`timescale 1ns/1ps

module perf_run_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 clear,
  input  perf_pkg::burst_cnt_t burst_num,
  input  logic                 burst_done,
  input  logic                 last_burst,
  output logic                 run_start,
  output logic                 stat_clear,
  output logic                 idle
);

  perf_pkg::run_state_t state;
  perf_pkg::run_state_t state_next;
  logic                 launch;

  // empty runs are dropped here
  assign launch = (state == perf_pkg::IDLE) && start && (burst_num != '0);

  always_comb begin
    state_next = state;
    case (state)
      perf_pkg::IDLE: begin
        if (launch) begin
          state_next = perf_pkg::RUNNING;
        end
      end
      perf_pkg::RUNNING: begin
        if (burst_done && last_burst) begin
          state_next = perf_pkg::IDLE;
        end
      end
      default: begin
        state_next = perf_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= perf_pkg::IDLE;
      run_start  <= 1'b0;
      stat_clear <= 1'b0;
    end else begin
      state      <= state_next;
      run_start  <= launch;
      stat_clear <= clear && (state == perf_pkg::IDLE);
    end
  end

  assign idle = (state == perf_pkg::IDLE);

  // only the first running cycle may carry the launch pulse
  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
    (state == perf_pkg::RUNNING) && $past(state == perf_pkg::RUNNING) |-> !run_start);

endmodule

// ==== hw/burst_counter.sv ====
`timescale 1ns/1ps

module burst_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run_start,
  input  logic                beat_done,
  input  logic                burst_done,
  input  perf_pkg::perf_cfg_t cfg,
  output perf_pkg::addr_t     burst_addr,
  output perf_pkg::data_t     beat_idx,
  output logic                last_beat,
  output logic                last_burst
);

  // beat within the current burst
  perf_pkg::beats_t     beat_cnt;
  perf_pkg::burst_cnt_t burst_idx;

  // ---------------------------------------------------------------------
  // indices
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt  <= '0;
      burst_idx <= '0;
      beat_idx  <= '0;
    end else if (run_start) begin
      beat_cnt  <= '0;
      burst_idx <= '0;
      beat_idx  <= '0;
    end else begin
      if (beat_done) begin
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        // run-wide index, also the write data
        beat_idx <= beat_idx + 1'b1;
      end
      if (burst_done) begin
        burst_idx <= burst_idx + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // burst start address
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (run_start) begin
      burst_addr <= cfg.base_addr;
    end else if (burst_done) begin
      burst_addr <= burst_addr + cfg.burst_stride;
    end
  end

  assign last_beat  = (beat_cnt == perf_pkg::beats_t'(cfg.burst_beats - 1'b1));
  assign last_burst = (burst_idx == perf_pkg::burst_cnt_t'(cfg.burst_num - 1'b1));

  // no w beat beyond the configured burst length
  a_beat_range: assert property (@(posedge clk) disable iff (!rst_n)
    beat_done |-> (beat_cnt < cfg.burst_beats));

  // the response only comes once every beat of the burst has gone out
  a_burst_complete: assert property (@(posedge clk) disable iff (!rst_n)
    burst_done |-> (beat_cnt == '0));

endmodule

// ==== hw/wr_channel.sv ====
`timescale 1ns/1ps

module wr_channel (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run_start,
  input  perf_pkg::perf_cfg_t cfg,
  input  perf_pkg::addr_t     burst_addr,
  input  perf_pkg::data_t     beat_idx,
  input  logic                last_beat,
  input  logic                last_burst,
  output logic                beat_done,
  output logic                burst_done,

  output logic                aw_valid,
  output perf_pkg::axi_aw_t   aw,
  input  logic                aw_ready,
  output logic                w_valid,
  output perf_pkg::axi_w_t    w,
  input  logic                w_ready,
  input  logic                b_valid,
  input  perf_pkg::axi_b_t    b,
  output logic                b_ready
);

  perf_pkg::wr_phase_t phase;
  logic                aw_hs;

  assign aw_hs      = aw_valid && aw_ready;
  assign beat_done  = w_valid && w_ready;
  assign burst_done = b_valid && b_ready;
  assign b_ready    = (phase == perf_pkg::RESP);

  // ---------------------------------------------------------------------
  // phase sequencing, one burst in flight
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase    <= perf_pkg::ADDR;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      case (phase)
        perf_pkg::ADDR: begin
          if (run_start) begin
            aw_valid <= 1'b1;
          end else if (aw_hs) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b1;
            phase    <= perf_pkg::DATA;
          end
        end
        perf_pkg::DATA: begin
          if (beat_done && last_beat) begin
            w_valid <= 1'b0;
            phase   <= perf_pkg::RESP;
          end
        end
        perf_pkg::RESP: begin
          if (burst_done) begin
            phase <= perf_pkg::ADDR;
            // next burst unless the run is over
            aw_valid <= !last_burst;
          end
        end
        default: begin
          phase <= perf_pkg::ADDR;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // payloads
  // ---------------------------------------------------------------------
  assign aw = '{
    addr:  burst_addr,
    id:    '0,
    len:   perf_pkg::beats_t'(cfg.burst_beats - 1'b1),
    size:  cfg.awsize,
    burst: perf_pkg::burst_incr
  };

  assign w = '{
    data: beat_idx,
    strb: '1,
    last: last_beat
  };

  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw));

  a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w));

  // response must belong to the burst we issued
  a_b_id: assert property (@(posedge clk) disable iff (!rst_n)
    burst_done |-> (b.id == aw.id));

endmodule

// ==== hw/wr_stats.sv ====
`timescale 1ns/1ps

module wr_stats (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stat_clear,
  input  logic                  aw_valid,
  input  logic                  aw_ready,
  input  logic                  w_valid,
  input  logic                  w_ready,
  input  logic                  b_valid,
  input  logic                  b_ready,
  input  perf_pkg::axi_b_t      b,
  output perf_pkg::perf_stats_t stats
);

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic b_err;

  // holds at all ones
  function automatic perf_pkg::stat_t sat_inc(input perf_pkg::stat_t cnt, input logic en);
    perf_pkg::stat_t nxt;
    nxt = cnt;
    if (en && (cnt != '1)) begin
      nxt = cnt + 1'b1;
    end
    return nxt;
  endfunction

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign b_hs  = b_valid && b_ready;
  assign b_err = b_hs && (b.resp != perf_pkg::resp_okay);

  // ---------------------------------------------------------------------
  // counters
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (stat_clear) begin
      stats <= '0;
    end else begin
      stats.aw_count    <= sat_inc(stats.aw_count, aw_hs);
      stats.w_count     <= sat_inc(stats.w_count, w_hs);
      stats.b_count     <= sat_inc(stats.b_count, b_hs);
      stats.b_err_count <= sat_inc(stats.b_err_count, b_err);
    end
  end

endmodule

// ==== hw/axi_perf_top.sv ====
`timescale 1ns/1ps

module axi_perf_top (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  start,
  input  logic                  clear,
  input  perf_pkg::perf_cfg_t   cfg,
  output logic                  idle,
  output perf_pkg::perf_stats_t stats,

  output logic                  aw_valid,
  output perf_pkg::axi_aw_t     aw,
  input  logic                  aw_ready,
  output logic                  w_valid,
  output perf_pkg::axi_w_t      w,
  input  logic                  w_ready,
  input  logic                  b_valid,
  input  perf_pkg::axi_b_t      b,
  output logic                  b_ready
);

  logic            run_start;
  logic            stat_clear;
  logic            beat_done;
  logic            burst_done;
  perf_pkg::addr_t burst_addr;
  perf_pkg::data_t beat_idx;
  logic            last_beat;
  logic            last_burst;

  // ---------------------------------------------------------------------
  // run control
  // ---------------------------------------------------------------------
  perf_run_ctrl u_perf_run_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .clear      (clear),
    .burst_num  (cfg.burst_num),
    .burst_done (burst_done),
    .last_burst (last_burst),
    .run_start  (run_start),
    .stat_clear (stat_clear),
    .idle       (idle)
  );

  burst_counter u_burst_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .run_start  (run_start),
    .beat_done  (beat_done),
    .burst_done (burst_done),
    .cfg        (cfg),
    .burst_addr (burst_addr),
    .beat_idx   (beat_idx),
    .last_beat  (last_beat),
    .last_burst (last_burst)
  );

  // ---------------------------------------------------------------------
  // write channels and statistics
  // ---------------------------------------------------------------------
  wr_channel u_wr_channel (
    .clk        (clk),
    .rst_n      (rst_n),
    .run_start  (run_start),
    .cfg        (cfg),
    .burst_addr (burst_addr),
    .beat_idx   (beat_idx),
    .last_beat  (last_beat),
    .last_burst (last_burst),
    .beat_done  (beat_done),
    .burst_done (burst_done),
    .aw_valid   (aw_valid),
    .aw         (aw),
    .aw_ready   (aw_ready),
    .w_valid    (w_valid),
    .w          (w),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b          (b),
    .b_ready    (b_ready)
  );

  wr_stats u_wr_stats (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .b          (b),
    .stats      (stats)
  );

endmodule

// ==== bench/axi_wr_responder.sv ====
`timescale 1ns/1ps

module axi_wr_responder (
  input  logic             clk,
  input  logic             rst_n,
  output logic             aw_ready,
  input  logic             w_valid,
  input  perf_pkg::axi_w_t w,
  output logic             w_ready,
  output logic             b_valid,
  output perf_pkg::axi_b_t b,
  input  logic             b_ready,
  output int               err_sent
);

  localparam logic [1:0] resp_slverr = 2'b10;

  logic [31:0]      lcg_q      = 32'd13078;
  logic             aw_ready_q = 1'b0;
  logic             w_ready_q  = 1'b0;
  logic             b_valid_q  = 1'b0;
  perf_pkg::axi_b_t b_q        = '0;
  logic             b_pending  = 1'b0;
  logic [1:0]       b_delay    = 2'd0;
  int               err_q      = 0;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ---------------------------------------------------------------------
  // random ready and delayed response
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    lcg_q <= lcg_next(lcg_q);
    if (!rst_n) begin
      aw_ready_q <= 1'b0;
      w_ready_q  <= 1'b0;
      b_valid_q  <= 1'b0;
      b_pending  <= 1'b0;
    end else begin
      // ready about three cycles out of four
      aw_ready_q <= (lcg_q[17:16] != 2'b00);
      w_ready_q  <= (lcg_q[19:18] != 2'b00);
      if (w_valid && w_ready_q && w.last) begin
        b_pending <= 1'b1;
        b_delay   <= lcg_q[21:20];
      end else if (b_pending) begin
        if (b_delay == 2'd0) begin
          b_pending  <= 1'b0;
          b_valid_q  <= 1'b1;
          b_q.id     <= '0;
          b_q.resp   <= (lcg_q[23:22] == 2'b00) ? resp_slverr : 2'b00;
        end else begin
          b_delay <= b_delay - 2'd1;
        end
      end
      if (b_valid_q && b_ready) begin
        b_valid_q <= 1'b0;
        if (b_q.resp != 2'b00) begin
          err_q <= err_q + 1;
        end
        $display("responder: B response 0x%0h sent", b_q.resp);
      end
    end
  end

  assign aw_ready = aw_ready_q;
  assign w_ready  = w_ready_q;
  assign b_valid  = b_valid_q;
  assign b        = b_q;
  assign err_sent = err_q;

endmodule

// ==== bench/tb_axi_perf.sv ====
`timescale 1ns/1ps

module tb_axi_perf;

  localparam int n_runs = 4;

  logic                  clk   = 1'b0;
  logic                  rst_n = 1'b0;
  logic                  start = 1'b0;
  logic                  clear = 1'b0;
  perf_pkg::perf_cfg_t   cfg   = '0;
  logic                  idle;
  perf_pkg::perf_stats_t stats;
  logic                  aw_valid;
  perf_pkg::axi_aw_t     aw;
  logic                  aw_ready;
  logic                  w_valid;
  perf_pkg::axi_w_t      w;
  logic                  w_ready;
  logic                  b_valid;
  perf_pkg::axi_b_t      b;
  logic                  b_ready;
  int                    err_sent;

  perf_pkg::perf_cfg_t cfgs [n_runs];
  int errors   = 0;
  int checks   = 0;
  int cycles   = 0;
  int limit    = 0;
  int run_aw   = 0;
  int run_w    = 0;
  int run_b    = 0;
  int in_burst = 0;
  int exp_aw   = 0;
  int exp_w    = 0;
  int exp_b    = 0;
  int err_base = 0;
  logic idle_q = 1'b1;

  axi_perf_top u_axi_perf_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .clear    (clear),
    .cfg      (cfg),
    .idle     (idle),
    .stats    (stats),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready)
  );

  axi_wr_responder u_axi_wr_responder (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .err_sent (err_sent)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // AW of burst k, straight from the address rule
  function automatic perf_pkg::axi_aw_t expected_aw(input int k, input perf_pkg::perf_cfg_t c);
    perf_pkg::axi_aw_t a;
    a.addr  = c.base_addr + perf_pkg::addr_t'(k) * c.burst_stride;
    a.id    = '0;
    a.len   = c.burst_beats - 8'd1;
    a.size  = c.awsize;
    a.burst = 2'b01;
    return a;
  endfunction

  function automatic int cycle_limit();
    int sum;
    sum = 0;
    for (int i = 0; i < n_runs; i++) begin
      sum += int'(cfgs[i].burst_num) * (int'(cfgs[i].burst_beats) + 3);
    end
    return sum * 8 + 200;
  endfunction

  task automatic wait_idle(input logic level);
    do begin
      @(posedge clk);
    end while (idle !== level);
  endtask

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  task automatic do_run(input perf_pkg::perf_cfg_t c, input bit restart);
    @(posedge clk);
    cfg   <= c;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_idle(1'b0);
    if (restart) begin
      repeat (3) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    wait_idle(1'b1);
    exp_aw += int'(c.burst_num);
    exp_w  += int'(c.burst_num) * int'(c.burst_beats);
    exp_b  += int'(c.burst_num);
    check("run aw bursts", 64'(run_aw), 64'(c.burst_num));
    check("run w beats", 64'(run_w), 64'(int'(c.burst_num) * int'(c.burst_beats)));
    check("run b responses", 64'(run_b), 64'(c.burst_num));
    check("stats.aw_count", 64'(stats.aw_count), 64'(exp_aw));
    check("stats.w_count", 64'(stats.w_count), 64'(exp_w));
    check("stats.b_count", 64'(stats.b_count), 64'(exp_b));
    check("stats.b_err_count", 64'(stats.b_err_count), 64'(err_sent - err_base));
  endtask

  task automatic empty_start();
    perf_pkg::perf_cfg_t c;
    c = cfgs[2];
    c.burst_num = '0;
    @(posedge clk);
    cfg   <= c;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (3) begin
      @(posedge clk);
      check("idle", 64'(idle), 64'd1);
      check("aw_valid", 64'(aw_valid), 64'd0);
    end
  endtask

  task automatic clear_stats();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    // stat_clear one edge later, zero after the next
    repeat (2) @(posedge clk);
    check("stats", 64'(stats.aw_count | stats.w_count), 64'd0);
    check("stats", 64'(stats.b_count | stats.b_err_count), 64'd0);
    exp_aw   = 0;
    exp_w    = 0;
    exp_b    = 0;
    err_base = err_sent;
  endtask

  initial begin
    // base, beats, stride, bursts, size
    cfgs[0] = '{20'h00100, 8'd4, 20'h00040, 16'd3, 3'd1};
    cfgs[1] = '{20'hfff00, 8'd1, 20'h00060, 16'd5, 3'd0};
    cfgs[2] = '{20'h01000, 8'd8, 20'h00100, 16'd2, 3'd1};
    cfgs[3] = '{20'h20000, 8'd3, 20'h00006, 16'd4, 3'd1};
    limit = cycle_limit();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check("idle", 64'(idle), 64'd1);
    check("aw_valid", 64'(aw_valid), 64'd0);
    check("w_valid", 64'(w_valid), 64'd0);
    check("b_ready", 64'(b_ready), 64'd0);
    check("stats", 64'(stats.aw_count | stats.w_count | stats.b_count), 64'd0);
    check("stats.b_err_count", 64'(stats.b_err_count), 64'd0);
    do_run(cfgs[0], 1'b0);
    do_run(cfgs[1], 1'b0);
    do_run(cfgs[2], 1'b1);
    empty_start();
    clear_stats();
    do_run(cfgs[3], 1'b0);
    @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // ---------------------------------------------------------------------
  // compare every handshake
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (idle_q && !idle) begin
        run_aw   = 0;
        run_w    = 0;
        run_b    = 0;
        in_burst = 0;
      end
      if (aw_valid && aw_ready) begin
        check("aw", 64'(aw), 64'(expected_aw(run_aw, cfg)));
        run_aw++;
      end
      if (w_valid && w_ready) begin
        check("w.data", 64'(w.data), 64'(run_w[15:0]));
        check("w.strb", 64'(w.strb), 64'h3);
        check("w.last", 64'(w.last), 64'(in_burst == int'(cfg.burst_beats) - 1));
        in_burst = (in_burst == int'(cfg.burst_beats) - 1) ? 0 : in_burst + 1;
        run_w++;
      end
      if (b_valid && b_ready) begin
        run_b++;
      end
    end
    idle_q = idle;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
hw/perf_pkg.sv
hw/perf_run_ctrl.sv
hw/burst_counter.sv
hw/wr_channel.sv
hw/wr_stats.sv
hw/axi_perf_top.sv
bench/axi_wr_responder.sv
bench/tb_axi_perf.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_perf -f sim.f -o tb_axi_perf; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_axi_perf > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1
